/* all.f */
hw/wo_filter_pkg.sv
hw/wo_req_hash.sv
hw/wo_filter_cam.sv
hw/wo_slot_alloc.sv
hw/wo_issue_ctrl.sv
hw/wo_order_filter.sv
verif/wo_filter_checker.sv
verif/tb_wo_order_filter.sv

/* hw/wo_filter_cam.sv */
/*
 * In-flight hash filter
 * One hash and a valid bit per tracking slot. A test value is compared
 * against every valid entry in one combinational step. Entries are
 * written by slot index on issue and invalidated by slot on completion
 */

`default_nettype none

module wo_filter_cam #(
    parameter int N_SLOTS   = 16,
    parameter int HASH_BITS = 8
) (
    input  wire logic                        clk,
    input  wire logic                        resetb,

    // Presence test
    input  wire logic [HASH_BITS-1:0]        test_value,
    input  wire logic                        test_en,
    output logic                             hit,

    // Insert at a slot chosen outside
    input  wire logic                        insert_en,
    input  wire logic [$clog2(N_SLOTS)-1:0]  insert_idx,
    input  wire logic [HASH_BITS-1:0]        insert_value,

    // Invalidate a slot
    input  wire logic                        remove_en,
    input  wire logic [$clog2(N_SLOTS)-1:0]  remove_idx
);

    typedef logic [HASH_BITS-1:0] hash_t;

    // Entry storage
    hash_t              values [N_SLOTS];
    logic [N_SLOTS-1:0] valid;

    // Per-slot compare result
    logic [N_SLOTS-1:0] test_match;

    always_comb
    begin
        for (int s = 0; s < N_SLOTS; s++)
        begin
            test_match[s] = (values[s] == test_value);
        end
    end

    // A stale value in an invalid slot never counts
    assign hit = test_en && |(valid & test_match);

    // Valid bits
    // A remove on the same slot as an insert would win, but the slot
    // tracker never offers a slot that is still busy
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            valid <= '0;
        end
        else
        begin
            if (insert_en)
            begin
                valid[insert_idx] <= 1'b1;
            end
            if (remove_en)
            begin
                valid[remove_idx] <= 1'b0;
            end
        end
    end

    // Hash values
    always_ff @(posedge clk)
    begin
        if (insert_en)
        begin
            values[insert_idx] <= insert_value;
        end
    end

    // Slot tracker and filter agree on which slots are in flight
    a_insert_free_slot: assert property (@(posedge clk) disable iff (!resetb)
        insert_en |-> !valid[insert_idx])
        else $error("insert into a valid slot %0d", insert_idx);

endmodule

`default_nettype wire

/* hw/wo_filter_pkg.sv */
/*
 * Write-ordering filter shared definitions
 * Address type, cache line geometry and the default sizes of the
 * in-flight tracking structures, shared by RTL and testbench
 */

`default_nettype none

package wo_filter_pkg;

    // Byte address width of a request
    localparam int ADDR_BITS = 32;

    // Byte address of a request
    typedef logic [ADDR_BITS-1:0] addr_t;

    // Low address bits that select a byte inside one cache line
    // 64-byte lines
    localparam int LINE_OFFSET = 6;

    // Default number of in-flight slots
    // Power of two, 2 to 64
    localparam int DEF_N_SLOTS = 16;

    // Default width of the folded line hash
    // 4 to 16 bits
    localparam int DEF_HASH_BITS = 8;

endpackage

`default_nettype wire

/* hw/wo_issue_ctrl.sv */
/*
 * Issue controller
 * Issues the staged request when its hash is not in flight and a slot
 * is free, inserting the hash at that slot in the same cycle. Otherwise
 * holds the request, raises the stall and retries every cycle
 */

`default_nettype none

module wo_issue_ctrl #(
    parameter int N_SLOTS = 16
) (
    input  wire logic                        clk,
    input  wire logic                        resetb,
    input  wire logic                        stg_valid,
    input  wire wo_filter_pkg::addr_t        stg_addr,
    input  wire logic                        hit,
    input  wire logic                        free_valid,
    input  wire logic [$clog2(N_SLOTS)-1:0]  free_idx,
    output logic                             stg_take,
    output logic                             ins_en,
    output logic [$clog2(N_SLOTS)-1:0]       ins_idx,
    output logic                             issue_en,
    output wo_filter_pkg::addr_t             issue_addr,
    output logic [$clog2(N_SLOTS)-1:0]       issue_tag,
    output logic                             req_stall
);

    typedef enum logic [0:0] {
        st_idle,
        st_hold
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   go;

    // Hash absent and a slot to put it in
    assign go = stg_valid && !hit && free_valid;

    // Filter insert and slot allocate land on the issuing edge
    assign ins_en   = go;
    assign ins_idx  = free_idx;
    assign stg_take = go;

    // Blocked request parks in hold until it goes
    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:
                if (stg_valid && !go)
                    state_nxt = st_hold;
            st_hold:
                if (go)
                    state_nxt = st_idle;
            default:
                state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state    <= st_idle;
            issue_en <= 1'b0;
        end
        else
        begin
            state    <= state_nxt;
            issue_en <= go;
        end
    end

    // Issue payload is only meaningful while issue_en is high
    always_ff @(posedge clk)
    begin
        if (go)
        begin
            issue_addr <= stg_addr;
            issue_tag  <= free_idx;
        end
    end

    // Stall level is the registered hold state
    assign req_stall = (state == st_hold);

    a_issue_not_stalled: assert property (@(posedge clk) disable iff (!resetb)
        !(issue_en && req_stall))
        else $error("issue_en together with req_stall");

endmodule

`default_nettype wire

/* hw/wo_order_filter.sv */
/*
 * Write-ordering filter top
 * Keeps two writes to the same cache line hash from being in flight
 * together. Capture stage, in-flight filter, slot tracker and issue
 * controller; completions free the filter entry and the slot
 */

`default_nettype none

module wo_order_filter #(
    parameter int N_SLOTS   = wo_filter_pkg::DEF_N_SLOTS,
    parameter int HASH_BITS = wo_filter_pkg::DEF_HASH_BITS
) (
    input  wire logic                        clk,
    input  wire logic                        resetb,

    // Request side
    input  wire logic                        req_en,
    input  wire wo_filter_pkg::addr_t        req_addr,
    output logic                             req_stall,

    // Issue side
    output logic                             issue_en,
    output wo_filter_pkg::addr_t             issue_addr,
    output logic [$clog2(N_SLOTS)-1:0]       issue_tag,

    // Completion by tag
    input  wire logic                        cpl_en,
    input  wire logic [$clog2(N_SLOTS)-1:0]  cpl_tag
);

    localparam int TAG_BITS = $clog2(N_SLOTS);

    // Stage to controller and filter
    logic                  stg_valid;
    wo_filter_pkg::addr_t  stg_addr;
    logic [HASH_BITS-1:0]  stg_hash;
    logic                  stg_take;

    // Filter and slot state
    logic                  hit;
    logic                  free_valid;
    logic [TAG_BITS-1:0]   free_idx;

    // Insert on issue
    logic                  ins_en;
    logic [TAG_BITS-1:0]   ins_idx;

    wo_req_hash #(
        .HASH_BITS (HASH_BITS)
    ) i_wo_req_hash (
        .clk       (clk),
        .resetb    (resetb),
        .req_en    (req_en),
        .req_addr  (req_addr),
        .req_stall (req_stall),
        .stg_take  (stg_take),
        .stg_valid (stg_valid),
        .stg_addr  (stg_addr),
        .stg_hash  (stg_hash)
    );

    wo_filter_cam #(
        .N_SLOTS   (N_SLOTS),
        .HASH_BITS (HASH_BITS)
    ) i_wo_filter_cam (
        .clk          (clk),
        .resetb       (resetb),
        .test_value   (stg_hash),
        .test_en      (stg_valid),
        .hit          (hit),
        .insert_en    (ins_en),
        .insert_idx   (ins_idx),
        .insert_value (stg_hash),
        .remove_en    (cpl_en),
        .remove_idx   (cpl_tag)
    );

    wo_slot_alloc #(
        .N_SLOTS (N_SLOTS)
    ) i_wo_slot_alloc (
        .clk         (clk),
        .resetb      (resetb),
        .alloc_en    (ins_en),
        .alloc_idx   (ins_idx),
        .release_en  (cpl_en),
        .release_idx (cpl_tag),
        .free_valid  (free_valid),
        .free_idx    (free_idx)
    );

    wo_issue_ctrl #(
        .N_SLOTS (N_SLOTS)
    ) i_wo_issue_ctrl (
        .clk        (clk),
        .resetb     (resetb),
        .stg_valid  (stg_valid),
        .stg_addr   (stg_addr),
        .hit        (hit),
        .free_valid (free_valid),
        .free_idx   (free_idx),
        .stg_take   (stg_take),
        .ins_en     (ins_en),
        .ins_idx    (ins_idx),
        .issue_en   (issue_en),
        .issue_addr (issue_addr),
        .issue_tag  (issue_tag),
        .req_stall  (req_stall)
    );

endmodule

`default_nettype wire

/* hw/wo_req_hash.sv */
/*
 * Request capture stage
 * Registers one accepted write request and folds its line address into
 * a short hash, then holds both until the issue controller takes them
 */

`default_nettype none

module wo_req_hash #(
    parameter int HASH_BITS = 8
) (
    input  wire logic                  clk,
    input  wire logic                  resetb,
    input  wire logic                  req_en,
    input  wire wo_filter_pkg::addr_t  req_addr,
    input  wire logic                  req_stall,
    input  wire logic                  stg_take,
    output logic                       stg_valid,
    output wo_filter_pkg::addr_t       stg_addr,
    output logic [HASH_BITS-1:0]       stg_hash
);

    // Line address width once the byte offset is dropped
    localparam int LINE_BITS = wo_filter_pkg::ADDR_BITS - wo_filter_pkg::LINE_OFFSET;
    // Chunks of the line address, the top one zero padded
    localparam int N_CHUNKS = (LINE_BITS + HASH_BITS - 1) / HASH_BITS;

    logic [LINE_BITS-1:0] line_addr;
    logic [HASH_BITS-1:0] fold;
    logic                 load;

    assign line_addr = LINE_BITS'(req_addr >> wo_filter_pkg::LINE_OFFSET);

    // XOR of all chunks, taken from bit 0 upward
    always_comb
    begin
        fold = '0;
        for (int i = 0; i < N_CHUNKS; i++)
        begin
            fold = fold ^ HASH_BITS'(line_addr >> (i * HASH_BITS));
        end
    end

    // Stage accepts only when empty or being drained this cycle
    assign load = req_en && (!stg_valid || stg_take);

    always_ff @(posedge clk)
    begin
        if (!resetb)
            stg_valid <= 1'b0;
        else if (load)
            stg_valid <= 1'b1;
        else if (stg_take)
            stg_valid <= 1'b0;
    end

    // Payload follows the valid bit
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            stg_addr <= req_addr;
            stg_hash <= fold;
        end
    end

    // Driver honours the stall and never overruns a held stage
    a_req_while_held: assert property (@(posedge clk) disable iff (!resetb)
        req_en |-> !req_stall && (!stg_valid || stg_take))
        else $error("req_en while stage is held");

endmodule

`default_nettype wire

/* hw/wo_slot_alloc.sv */
/*
 * Free-slot tracker
 * Busy bit per tracking slot. Offers the lowest free slot every cycle,
 * marks it busy on allocate and frees a slot on completion
 */

`default_nettype none

module wo_slot_alloc #(
    parameter int N_SLOTS = 16
) (
    input  wire logic                        clk,
    input  wire logic                        resetb,
    input  wire logic                        alloc_en,
    input  wire logic [$clog2(N_SLOTS)-1:0]  alloc_idx,
    input  wire logic                        release_en,
    input  wire logic [$clog2(N_SLOTS)-1:0]  release_idx,
    output logic                             free_valid,
    output logic [$clog2(N_SLOTS)-1:0]       free_idx
);

    localparam int TAG_BITS = $clog2(N_SLOTS);

    logic [N_SLOTS-1:0] busy;

    // Priority encoder, lowest free index wins
    // Walk down so the last hit is the lowest slot
    always_comb
    begin
        free_valid = 1'b0;
        free_idx   = '0;
        for (int i = N_SLOTS - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                free_valid = 1'b1;
                free_idx   = TAG_BITS'(i);
            end
        end
    end

    // Busy vector
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            busy <= '0;
        end
        else
        begin
            if (alloc_en)
            begin
                busy[alloc_idx] <= 1'b1;
            end
            // Released slot is offered again from the next cycle on
            if (release_en)
            begin
                busy[release_idx] <= 1'b0;
            end
        end
    end

    // Completions only name tags that are out
    a_release_busy: assert property (@(posedge clk) disable iff (!resetb)
        release_en |-> busy[release_idx])
        else $error("release of idle slot %0d", release_idx);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/bash
# Build and run the write-ordering filter testbench with Verilator
set -e -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_wo_order_filter -f all.f
./obj_dir/Vtb_wo_order_filter | tee sim.log

if grep -q -F '*** FAILED ***' sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* verif/tb_wo_order_filter.sv */
/*
 * Write-ordering filter testbench
 * Drives a table of write requests into the filter, returns each
 * issued tag after its row's delay, and stops a hung run by a watchdog
 */

`default_nettype none

module tb_wo_order_filter;

    localparam int N_SLOTS   = wo_filter_pkg::DEF_N_SLOTS;
    localparam int HASH_BITS = wo_filter_pkg::DEF_HASH_BITS;
    localparam int TAG_BITS  = $clog2(N_SLOTS);

    logic                  clk;
    logic                  resetb;
    logic                  req_en;
    wo_filter_pkg::addr_t  req_addr;
    logic                  req_stall;
    logic                  issue_en;
    wo_filter_pkg::addr_t  issue_addr;
    logic [TAG_BITS-1:0]   issue_tag;
    logic                  cpl_en = 1'b0;
    logic [TAG_BITS-1:0]   cpl_tag = '0;
    int                    error_count;
    int                    issue_count;

    // Stimulus table, one entry per row in each queue
    string                 row_name  [$];
    wo_filter_pkg::addr_t  row_addr  [$];
    int                    row_delay [$];

    // Completions waiting for their cycle
    int                    cpl_due   [$];
    logic [TAG_BITS-1:0]   cpl_tags  [$];
    int                    now_cycle;
    int                    rows_issued;

    logic [31:0]           lfsr = 32'hec83_ef90;

    wo_order_filter #(
        .N_SLOTS   (N_SLOTS),
        .HASH_BITS (HASH_BITS)
    ) i_wo_order_filter (
        .clk        (clk),
        .resetb     (resetb),
        .req_en     (req_en),
        .req_addr   (req_addr),
        .req_stall  (req_stall),
        .issue_en   (issue_en),
        .issue_addr (issue_addr),
        .issue_tag  (issue_tag),
        .cpl_en     (cpl_en),
        .cpl_tag    (cpl_tag)
    );

    wo_filter_checker #(
        .N_SLOTS   (N_SLOTS),
        .HASH_BITS (HASH_BITS)
    ) i_wo_filter_checker (
        .clk         (clk),
        .resetb      (resetb),
        .req_en      (req_en),
        .req_addr    (req_addr),
        .req_stall   (req_stall),
        .issue_en    (issue_en),
        .issue_addr  (issue_addr),
        .issue_tag   (issue_tag),
        .cpl_en      (cpl_en),
        .cpl_tag     (cpl_tag),
        .error_count (error_count),
        .issue_count (issue_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic int random_bits(int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic add_row(string name, wo_filter_pkg::addr_t addr, int delay);
        row_name.push_back(name);
        row_addr.push_back(addr);
        row_delay.push_back(delay);
    endtask

    task automatic build_table();
        // Distinct lines, no conflict
        add_row("dist_0", 32'h0000_1000, 2);
        add_row("dist_1", 32'h0000_2040, 2);
        add_row("dist_2", 32'h0000_3080, 2);
        add_row("dist_3", 32'h0000_40c0, 2);
        // Same line, second one waits for the first completion
        add_row("same_a", 32'h0000_9000, 12);
        add_row("same_b", 32'h0000_9024, 3);
        // Lines 0x1, 0x100 and 0x10101 all fold to hash 0x01
        add_row("alias_a", 32'h0000_0040, 10);
        add_row("alias_b", 32'h0000_4000, 3);
        add_row("alias_c", 32'h0040_4040, 2);
        // Random delays, some rows share a line
        add_row("rnd_0", 32'h0001_0000, 1 + random_bits(4));
        add_row("rnd_1", 32'h0001_0020, 1 + random_bits(4));
        add_row("rnd_2", 32'h0002_0000, 1 + random_bits(4));
        add_row("rnd_3", 32'h0003_0000, 1 + random_bits(4));
        add_row("rnd_4", 32'h0002_0030, 1 + random_bits(4));
        add_row("rnd_5", 32'h0005_0000, 1 + random_bits(4));
        // Fill every slot with long-lived writes, then one more
        for (int i = 0; i < N_SLOTS; i++)
            add_row($sformatf("fill_%0d", i), 32'h0010_0000 + 32'(i * 64), 60);
        add_row("over", 32'h0020_0000, 2);
        add_row("tail", 32'h0000_1000, 1);
    endtask

    // Completion responder, at most one completion per cycle
    always @(posedge clk)
    begin
        int pick;
        if (!resetb)
        begin
            cpl_en      <= 1'b0;
            now_cycle   = 0;
            rows_issued = 0;
            cpl_due.delete();
            cpl_tags.delete();
        end
        else
        begin
            now_cycle++;
            pick = -1;
            // Rows issue in table order
            if (issue_en)
            begin
                if (rows_issued < row_delay.size())
                    cpl_due.push_back(now_cycle + row_delay[rows_issued]);
                else
                    cpl_due.push_back(now_cycle);
                cpl_tags.push_back(issue_tag);
                rows_issued++;
            end
            foreach (cpl_due[i])
                if (pick < 0 && cpl_due[i] <= now_cycle)
                    pick = i;
            cpl_en <= (pick >= 0);
            if (pick >= 0)
            begin
                cpl_tag <= cpl_tags[pick];
                cpl_due.delete(pick);
                cpl_tags.delete(pick);
            end
        end
    end

    initial
    begin
        int max_delay;
        int limit;
        resetb   = 1'b0;
        req_en   = 1'b0;
        req_addr = '0;
        build_table();
        max_delay = 0;
        foreach (row_delay[i])
            if (row_delay[i] > max_delay)
                max_delay = row_delay[i];
        limit = row_name.size() * (max_delay + 20) * 8;
        // Watchdog
        fork
            begin
                #(limit);
                $display("timeout: only %0d of %0d rows issued", issue_count, row_name.size());
                $display("*** FAILED ***");
                $finish;
            end
        join_none
        repeat (3) @(posedge clk);
        resetb <= 1'b1;
        @(posedge clk);
        foreach (row_name[i])
        begin
            i_wo_filter_checker.expect_request(row_name[i]);
            req_en   <= 1'b1;
            req_addr <= row_addr[i];
            @(posedge clk);
            req_en <= 1'b0;
            // Stall of this request shows two edges after it is sampled
            repeat (2) @(posedge clk);
            while (req_stall)
                @(posedge clk);
        end
        while (issue_count < row_name.size())
            @(posedge clk);
        while (cpl_due.size() != 0 || cpl_en)
            @(posedge clk);
        repeat (2) @(posedge clk);
        i_wo_filter_checker.print_summary(row_name.size());
        if (error_count == 0 && issue_count == row_name.size())
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/wo_filter_checker.sv */
/*
 * Write-ordering filter checker
 * Keeps its own model of in-flight line hashes and slots, predicts on
 * every edge whether the staged request issues, and compares the issue
 * strobe, stall level, address and tag with the DUT
 */

`default_nettype none

module wo_filter_checker #(
    parameter int N_SLOTS   = 16,
    parameter int HASH_BITS = 8
) (
    input  wire logic                        clk,
    input  wire logic                        resetb,
    input  wire logic                        req_en,
    input  wire wo_filter_pkg::addr_t        req_addr,
    input  wire logic                        req_stall,
    input  wire logic                        issue_en,
    input  wire wo_filter_pkg::addr_t        issue_addr,
    input  wire logic [$clog2(N_SLOTS)-1:0]  issue_tag,
    input  wire logic                        cpl_en,
    input  wire logic [$clog2(N_SLOTS)-1:0]  cpl_tag,
    output int                               error_count,
    output int                               issue_count
);

    localparam int TAG_BITS  = $clog2(N_SLOTS);
    localparam int LINE_BITS = wo_filter_pkg::ADDR_BITS - wo_filter_pkg::LINE_OFFSET;

    // Model of the in-flight slots
    logic                  slot_busy [N_SLOTS];
    logic [HASH_BITS-1:0]  slot_hash [N_SLOTS];

    // Request sitting in the DUT stage
    logic                  have_req;
    wo_filter_pkg::addr_t  held_addr;
    logic [HASH_BITS-1:0]  held_hash;
    int                    held_cycle;
    string                 held_name;

    // Completion taken by the DUT on the previous edge
    logic                  cpl_seen;
    logic [TAG_BITS-1:0]   cpl_seen_tag;

    int                    cycle;
    string                 names [$];

    // Bit b of the line address folds into hash bit b mod HASH_BITS
    function automatic logic [HASH_BITS-1:0] line_hash(wo_filter_pkg::addr_t addr);
        logic [LINE_BITS-1:0] line;
        logic [HASH_BITS-1:0] h;
        line = LINE_BITS'(addr >> wo_filter_pkg::LINE_OFFSET);
        h    = '0;
        for (int b = 0; b < LINE_BITS; b++)
            h[b % HASH_BITS] = h[b % HASH_BITS] ^ line[b];
        return h;
    endfunction

    function automatic logic hash_in_flight(logic [HASH_BITS-1:0] h);
        logic found;
        found = 1'b0;
        for (int s = 0; s < N_SLOTS; s++)
            if (slot_busy[s] && slot_hash[s] == h)
                found = 1'b1;
        return found;
    endfunction

    // Lowest free slot, -1 when all are out
    function automatic int lowest_free();
        int idx;
        idx = -1;
        for (int s = 0; s < N_SLOTS; s++)
            if (idx < 0 && !slot_busy[s])
                idx = s;
        return idx;
    endfunction

    task automatic report_mismatch(string name, string what, logic [31:0] expected,
                                   logic [31:0] actual);
        $display("mismatch %s %s: expected %0h actual %0h", name, what, expected, actual);
        error_count++;
    endtask

    // Row names arrive in request order
    task automatic expect_request(string name);
        names.push_back(name);
    endtask

    task automatic print_summary(int rows);
        $display("rows %0d issued %0d errors %0d", rows, issue_count, error_count);
    endtask

    always @(posedge clk)
    begin
        int   free_slot;
        logic staged;
        logic exp_issue;
        logic exp_stall;
        if (!resetb)
        begin
            for (int s = 0; s < N_SLOTS; s++)
                slot_busy[s] = 1'b0;
            have_req    = 1'b0;
            cpl_seen    = 1'b0;
            cycle       = 0;
            error_count = 0;
            issue_count = 0;
        end
        else
        begin
            cycle++;
            // DUT tested the stage on the previous edge against this model
            staged    = have_req && (cycle >= held_cycle + 2);
            free_slot = lowest_free();
            exp_issue = staged && !hash_in_flight(held_hash) && (free_slot >= 0);
            exp_stall = staged && !exp_issue;
            if (issue_en !== exp_issue)
                report_mismatch(held_name, "issue_en", 32'(exp_issue), 32'(issue_en));
            if (req_stall !== exp_stall)
                report_mismatch(held_name, "req_stall", 32'(exp_stall), 32'(req_stall));
            if (exp_issue && issue_en)
            begin
                if (issue_addr !== held_addr)
                    report_mismatch(held_name, "issue_addr", held_addr, issue_addr);
                if (issue_tag !== TAG_BITS'(free_slot))
                    report_mismatch(held_name, "issue_tag", 32'(free_slot), 32'(issue_tag));
                if (slot_busy[issue_tag])
                begin
                    $display("error: %s got tag %0d while it is in flight", held_name,
                             issue_tag);
                    error_count++;
                end
                issue_count++;
                $display("row %-8s tag %0d latency %0d", held_name, issue_tag,
                         cycle - held_cycle);
            end
            // Remove lands before the insert of this edge is seen
            if (cpl_seen)
                slot_busy[cpl_seen_tag] = 1'b0;
            if (exp_issue)
            begin
                slot_busy[free_slot] = 1'b1;
                slot_hash[free_slot] = held_hash;
                have_req             = 1'b0;
            end
            cpl_seen     = cpl_en;
            cpl_seen_tag = cpl_tag;
            if (req_en)
            begin
                if (have_req)
                begin
                    $display("error: request accepted while %s is still held", held_name);
                    error_count++;
                end
                have_req   = 1'b1;
                held_addr  = req_addr;
                held_hash  = line_hash(req_addr);
                held_cycle = cycle;
                if (names.size() != 0)
                    held_name = names.pop_front();
                else
                    held_name = "unnamed";
            end
        end
    end

endmodule

`default_nettype wire
